// File: Bender.yml
package:
  name: haze_removal

sources:
  - design/dehaze_pkg.sv
  - design/pixel_delay.sv
  - design/adaptive_window_filter.sv
  - design/transmission_estimator.sv
  - design/scene_recovery.sv
  - design/haze_removal_top.sv
  - target: test
    files:
      - dv/haze_removal_props.sv
      - dv/tb_haze_removal.sv

// File: design/adaptive_window_filter.sv
// Edge classification of a 3x3 window and weighted filtering of its three channels
`timescale 1ns/1ps
`default_nettype none

module adaptive_window_filter #(
    parameter int EDGE_THRESHOLD = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p1,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p2,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p3,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p4,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p5,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p6,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p7,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p8,
    input  logic [dehaze_pkg::RGB_W-1:0] win_p9,
    output logic [dehaze_pkg::PIX_W-1:0] filt_r,
    output logic [dehaze_pkg::PIX_W-1:0] filt_g,
    output logic [dehaze_pkg::PIX_W-1:0] filt_b,
    output logic                         filt_valid
);

    localparam int PW = dehaze_pkg::PIX_W;

    // ======================================
    // Cycle 1: classify and register window
    // ======================================
    logic [PW-1:0]              diff_h;
    logic [PW-1:0]              diff_v;
    logic [PW:0]                gradient;
    dehaze_pkg::filter_mode_e   mode_d;
    dehaze_pkg::filter_mode_e   mode_q;
    logic [dehaze_pkg::RGB_W-1:0] win_q [9];
    logic                       valid_q;

    // Green gradient across the horizontal and vertical neighbours
    always_comb begin
        diff_h = dehaze_pkg::get_channel(win_p4, dehaze_pkg::CH_GREEN)
               - dehaze_pkg::get_channel(win_p6, dehaze_pkg::CH_GREEN);
        if (dehaze_pkg::get_channel(win_p6, dehaze_pkg::CH_GREEN) >
            dehaze_pkg::get_channel(win_p4, dehaze_pkg::CH_GREEN)) begin
            diff_h = -diff_h;
        end
        diff_v = dehaze_pkg::get_channel(win_p2, dehaze_pkg::CH_GREEN)
               - dehaze_pkg::get_channel(win_p8, dehaze_pkg::CH_GREEN);
        if (dehaze_pkg::get_channel(win_p8, dehaze_pkg::CH_GREEN) >
            dehaze_pkg::get_channel(win_p2, dehaze_pkg::CH_GREEN)) begin
            diff_v = -diff_v;
        end
        gradient = diff_h + diff_v;
        mode_d   = (gradient > EDGE_THRESHOLD) ? dehaze_pkg::MODE_EDGE : dehaze_pkg::MODE_SMOOTH;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 9; k++) begin
                win_q[k] <= '0;
            end
            mode_q  <= dehaze_pkg::MODE_SMOOTH;
            valid_q <= 1'b0;
        end else begin
            win_q[0] <= win_p1;
            win_q[1] <= win_p2;
            win_q[2] <= win_p3;
            win_q[3] <= win_p4;
            win_q[4] <= win_p5;
            win_q[5] <= win_p6;
            win_q[6] <= win_p7;
            win_q[7] <= win_p8;
            win_q[8] <= win_p9;
            mode_q   <= mode_d;
            valid_q  <= in_valid;
        end
    end

    // ======================================
    // Cycle 2: weighted sum per channel
    // ======================================
    logic [PW-1:0] px [9];
    logic [PW+1:0] corner_sum;
    logic [PW+1:0] edge_sum;
    logic [PW+3:0] acc;
    logic [PW-1:0] filt_d [3];

    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            for (int k = 0; k < 9; k++) begin
                px[k] = dehaze_pkg::get_channel(win_q[k], dehaze_pkg::channel_e'(ch));
            end
            corner_sum = px[0] + px[2] + px[6] + px[8];
            edge_sum   = px[1] + px[3] + px[5] + px[7];
            // Both weight sets sum to 16
            if (mode_q == dehaze_pkg::MODE_EDGE) begin
                acc = (edge_sum << 1) + (px[4] << 3);
            end else begin
                acc = corner_sum + (edge_sum << 1) + (px[4] << 2);
            end
            filt_d[ch] = acc[PW+3:4];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            filt_r     <= '0;
            filt_g     <= '0;
            filt_b     <= '0;
            filt_valid <= 1'b0;
        end else begin
            filt_r     <= filt_d[dehaze_pkg::CH_RED];
            filt_g     <= filt_d[dehaze_pkg::CH_GREEN];
            filt_b     <= filt_d[dehaze_pkg::CH_BLUE];
            filt_valid <= valid_q;
        end
    end

endmodule

`default_nettype wire

// File: design/dehaze_pkg.sv
// Widths, fixed-point constants, stage latencies, enums and a channel select helper
`default_nettype none

package dehaze_pkg;

    // ======================================
    // Data widths
    // ======================================
    localparam int PIX_W   = 8;
    localparam int RGB_W   = 3 * PIX_W;
    // Inverse atmospheric light, Q0.14
    localparam int INV_A_W = 14;
    // Haze fraction and transmission, Q0.8 with 256 meaning 1.0
    localparam int HAZE_W  = 9;
    // Reciprocal transmission, 4 fraction bits
    localparam int RECIP_W = 12;

    // ======================================
    // Fixed-point constants
    // ======================================
    // omega = 1 - 1/16
    localparam int OMEGA_SHIFT = 4;
    localparam int RECIP_NUM   = 4096;

    // ======================================
    // Stage latencies in cycles
    // ======================================
    localparam int FILTER_LAT = 2;
    localparam int ESTIM_LAT  = 2;
    localparam int RECOV_LAT  = 2;
    localparam int PIPE_LAT   = FILTER_LAT + ESTIM_LAT + RECOV_LAT;

    typedef enum logic {
        MODE_SMOOTH,
        MODE_EDGE
    } filter_mode_e;

    // Red sits in the high byte of a packed pixel
    typedef enum logic [1:0] {
        CH_RED,
        CH_GREEN,
        CH_BLUE
    } channel_e;

    function automatic logic [PIX_W-1:0] get_channel(logic [RGB_W-1:0] pix, channel_e ch);
        return pix[(CH_BLUE - ch) * PIX_W +: PIX_W];
    endfunction

endpackage

`default_nettype wire

// File: design/haze_removal_top.sv
// Top level of the dehazing pipeline with its filter, estimator, recovery and delay lines
`timescale 1ns/1ps
`default_nettype none

module haze_removal_top #(
    parameter int EDGE_THRESHOLD = 32,
    parameter int T_MIN          = 26
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p1,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p2,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p3,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p4,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p5,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p6,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p7,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p8,
    input  logic [dehaze_pkg::RGB_W-1:0]   win_p9,
    input  logic [dehaze_pkg::PIX_W-1:0]   atm_r,
    input  logic [dehaze_pkg::PIX_W-1:0]   atm_g,
    input  logic [dehaze_pkg::PIX_W-1:0]   atm_b,
    input  logic [dehaze_pkg::INV_A_W-1:0] inv_atm_r,
    input  logic [dehaze_pkg::INV_A_W-1:0] inv_atm_g,
    input  logic [dehaze_pkg::INV_A_W-1:0] inv_atm_b,
    output logic [dehaze_pkg::PIX_W-1:0]   out_r,
    output logic [dehaze_pkg::PIX_W-1:0]   out_g,
    output logic [dehaze_pkg::PIX_W-1:0]   out_b,
    output logic                           out_valid
);

    localparam int PW = dehaze_pkg::PIX_W;
    localparam int IW = dehaze_pkg::INV_A_W;

    logic [PW-1:0]                  filt_r;
    logic [PW-1:0]                  filt_g;
    logic [PW-1:0]                  filt_b;
    logic                           filt_valid;
    logic [IW-1:0]                  inv_r_d;
    logic [IW-1:0]                  inv_g_d;
    logic [IW-1:0]                  inv_b_d;
    logic [dehaze_pkg::RECIP_W-1:0] recip_t;
    logic                           est_valid;
    logic [dehaze_pkg::RGB_W-1:0]   center_d;
    logic [PW-1:0]                  atm_r_d;
    logic [PW-1:0]                  atm_g_d;
    logic [PW-1:0]                  atm_b_d;

    adaptive_window_filter #(
        .EDGE_THRESHOLD(EDGE_THRESHOLD)
    ) u_filter (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .win_p1    (win_p1),
        .win_p2    (win_p2),
        .win_p3    (win_p3),
        .win_p4    (win_p4),
        .win_p5    (win_p5),
        .win_p6    (win_p6),
        .win_p7    (win_p7),
        .win_p8    (win_p8),
        .win_p9    (win_p9),
        .filt_r    (filt_r),
        .filt_g    (filt_g),
        .filt_b    (filt_b),
        .filt_valid(filt_valid)
    );

    // Inverse light meets the filtered channels at the estimator
    pixel_delay #(
        .WIDTH(3 * IW),
        .DEPTH(dehaze_pkg::FILTER_LAT)
    ) u_inv_delay (
        .clk     (clk),
        .rst     (rst),
        .data_in ({inv_atm_r, inv_atm_g, inv_atm_b}),
        .data_out({inv_r_d, inv_g_d, inv_b_d})
    );

    transmission_estimator #(
        .T_MIN(T_MIN)
    ) u_estimator (
        .clk       (clk),
        .rst       (rst),
        .filt_valid(filt_valid),
        .filt_r    (filt_r),
        .filt_g    (filt_g),
        .filt_b    (filt_b),
        .inv_atm_r (inv_r_d),
        .inv_atm_g (inv_g_d),
        .inv_atm_b (inv_b_d),
        .recip_t   (recip_t),
        .est_valid (est_valid)
    );

    // Centre pixel and light ride alongside filter and estimator
    pixel_delay #(
        .WIDTH(dehaze_pkg::RGB_W + 3 * PW),
        .DEPTH(dehaze_pkg::FILTER_LAT + dehaze_pkg::ESTIM_LAT)
    ) u_pix_delay (
        .clk     (clk),
        .rst     (rst),
        .data_in ({win_p5, atm_r, atm_g, atm_b}),
        .data_out({center_d, atm_r_d, atm_g_d, atm_b_d})
    );

    scene_recovery u_recovery (
        .clk       (clk),
        .rst       (rst),
        .est_valid (est_valid),
        .recip_t   (recip_t),
        .center_pix(center_d),
        .atm_r     (atm_r_d),
        .atm_g     (atm_g_d),
        .atm_b     (atm_b_d),
        .out_r     (out_r),
        .out_g     (out_g),
        .out_b     (out_b),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// File: design/pixel_delay.sv
// Register chain that keeps side-band values aligned with the pipeline
`timescale 1ns/1ps
`default_nettype none

module pixel_delay #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    logic [WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign data_out = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: design/scene_recovery.sv
// Per-channel scene recovery A +/- |I - A| / t with clamping to 8 bits
`timescale 1ns/1ps
`default_nettype none

module scene_recovery (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           est_valid,
    input  logic [dehaze_pkg::RECIP_W-1:0] recip_t,
    input  logic [dehaze_pkg::RGB_W-1:0]   center_pix,
    input  logic [dehaze_pkg::PIX_W-1:0]   atm_r,
    input  logic [dehaze_pkg::PIX_W-1:0]   atm_g,
    input  logic [dehaze_pkg::PIX_W-1:0]   atm_b,
    output logic [dehaze_pkg::PIX_W-1:0]   out_r,
    output logic [dehaze_pkg::PIX_W-1:0]   out_g,
    output logic [dehaze_pkg::PIX_W-1:0]   out_b,
    output logic                           out_valid
);

    localparam int PW = dehaze_pkg::PIX_W;
    localparam int RW = dehaze_pkg::RECIP_W;

    // ======================================
    // Cycle 1: scaled difference
    // ======================================
    logic [dehaze_pkg::RGB_W-1:0] atm_pix;
    logic [PW-1:0]      i_ch;
    logic [PW-1:0]      a_ch;
    logic [PW-1:0]      diff;
    logic [PW+RW-1:0]   prod;
    logic [PW-1:0]      scaled_d [3];
    logic [2:0]         ge_d;
    logic [PW-1:0]      scaled_q [3];
    logic [2:0]         ge_q;
    logic [dehaze_pkg::RGB_W-1:0] atm_q;
    logic               valid_q;

    assign atm_pix = {atm_r, atm_g, atm_b};

    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            i_ch     = dehaze_pkg::get_channel(center_pix, dehaze_pkg::channel_e'(ch));
            a_ch     = dehaze_pkg::get_channel(atm_pix, dehaze_pkg::channel_e'(ch));
            ge_d[ch] = (i_ch >= a_ch);
            diff     = ge_d[ch] ? i_ch - a_ch : a_ch - i_ch;
            prod     = diff * recip_t;
            // Drop the 4 fraction bits of the reciprocal, then saturate
            scaled_d[ch] = (|prod[PW+RW-1:PW+4]) ? PW'(255) : prod[PW+3:4];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int ch = 0; ch < 3; ch++) begin
                scaled_q[ch] <= '0;
            end
            ge_q    <= '0;
            atm_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            scaled_q <= scaled_d;
            ge_q     <= ge_d;
            atm_q    <= atm_pix;
            valid_q  <= est_valid;
        end
    end

    // ======================================
    // Cycle 2: add or subtract and clamp
    // ======================================
    logic [PW-1:0] a2_ch;
    logic [PW:0]   sum;
    logic [PW-1:0] out_d [3];

    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            a2_ch = dehaze_pkg::get_channel(atm_q, dehaze_pkg::channel_e'(ch));
            sum   = a2_ch + scaled_q[ch];
            if (ge_q[ch]) begin
                out_d[ch] = sum[PW] ? PW'(255) : sum[PW-1:0];
            end else begin
                out_d[ch] = (scaled_q[ch] > a2_ch) ? '0 : a2_ch - scaled_q[ch];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_r     <= '0;
            out_g     <= '0;
            out_b     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_r     <= out_d[dehaze_pkg::CH_RED];
            out_g     <= out_d[dehaze_pkg::CH_GREEN];
            out_b     <= out_d[dehaze_pkg::CH_BLUE];
            out_valid <= valid_q;
        end
    end

endmodule

`default_nettype wire

// File: design/transmission_estimator.sv
// Dark channel, omega scaling, haze fraction, transmission floor and reciprocal table
`timescale 1ns/1ps
`default_nettype none

module transmission_estimator #(
    parameter int T_MIN = 26
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           filt_valid,
    input  logic [dehaze_pkg::PIX_W-1:0]   filt_r,
    input  logic [dehaze_pkg::PIX_W-1:0]   filt_g,
    input  logic [dehaze_pkg::PIX_W-1:0]   filt_b,
    input  logic [dehaze_pkg::INV_A_W-1:0] inv_atm_r,
    input  logic [dehaze_pkg::INV_A_W-1:0] inv_atm_g,
    input  logic [dehaze_pkg::INV_A_W-1:0] inv_atm_b,
    output logic [dehaze_pkg::RECIP_W-1:0] recip_t,
    output logic                           est_valid
);

    localparam int PW = dehaze_pkg::PIX_W;
    localparam int IW = dehaze_pkg::INV_A_W;
    localparam int HW = dehaze_pkg::HAZE_W;

    // ======================================
    // Cycle 1: dark channel and scaled inverse
    // ======================================
    dehaze_pkg::channel_e dark_ch;
    logic [PW-1:0]        dark_d;
    logic [IW-1:0]        inv_sel;
    logic [PW-1:0]        dark_q;
    logic [IW-1:0]        inv_q;
    logic                 valid_q;

    // Ties resolve towards red, then green
    always_comb begin
        if (filt_r <= filt_g && filt_r <= filt_b) begin
            dark_ch = dehaze_pkg::CH_RED;
        end else if (filt_g <= filt_b) begin
            dark_ch = dehaze_pkg::CH_GREEN;
        end else begin
            dark_ch = dehaze_pkg::CH_BLUE;
        end
        case (dark_ch)
            dehaze_pkg::CH_RED: begin
                dark_d  = filt_r;
                inv_sel = inv_atm_r;
            end
            dehaze_pkg::CH_GREEN: begin
                dark_d  = filt_g;
                inv_sel = inv_atm_g;
            end
            default: begin
                dark_d  = filt_b;
                inv_sel = inv_atm_b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dark_q  <= '0;
            inv_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            dark_q  <= dark_d;
            inv_q   <= inv_sel - (inv_sel >> dehaze_pkg::OMEGA_SHIFT);
            valid_q <= filt_valid;
        end
    end

    // ======================================
    // Cycle 2: transmission and reciprocal
    // ======================================
    logic [PW+IW-1:0] product;
    logic [HW-1:0]    haze;
    logic [HW-1:0]    trans_raw;
    logic [HW-1:0]    trans;
    logic [dehaze_pkg::RECIP_W-1:0] recip_lut [0:256];

    always_comb begin
        product   = dark_q * inv_q;
        // Product is Q0.14 times 8 bits, shift back to Q0.8
        haze      = (|product[PW+IW-1:14]) ? HW'(255) : HW'(product[13:6]);
        trans_raw = HW'(256) - haze;
        trans     = (trans_raw < HW'(T_MIN)) ? HW'(T_MIN) : trans_raw;
    end

    // Table entries below the floor are never addressed
    for (genvar t = 0; t <= 256; t++) begin : g_recip
        if (t >= T_MIN) begin : g_used
            assign recip_lut[t] = dehaze_pkg::RECIP_W'(dehaze_pkg::RECIP_NUM / t);
        end else begin : g_unused
            assign recip_lut[t] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            recip_t   <= '0;
            est_valid <= 1'b0;
        end else begin
            recip_t   <= recip_lut[trans];
            est_valid <= valid_q;
        end
    end

endmodule

`default_nettype wire

// File: dv/haze_removal_props.sv
// Concurrent assertions on pipeline timing, reset and output values, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module haze_removal_props (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    input  logic                         out_valid,
    input  logic [dehaze_pkg::PIX_W-1:0] out_r,
    input  logic [dehaze_pkg::PIX_W-1:0] out_g,
    input  logic [dehaze_pkg::PIX_W-1:0] out_b
);

    localparam int LAT = dehaze_pkg::PIPE_LAT;

    int violations = 0;

    // ========================================
    // Reset
    // ========================================
    a_low_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high while reset is active");
            violations++;
        end

    a_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid ##1 !out_valid)
        else begin
            $error("out_valid high right after reset");
            violations++;
        end

    // ========================================
    // Latency in both directions
    // ========================================
    a_in_to_out: assert property (@(posedge clk) disable iff (rst) in_valid |-> ##LAT out_valid)
        else begin
            $error("Input strobe without an output at the pipeline latency");
            violations++;
        end

    a_out_from_in: assert property (@(posedge clk) disable iff (rst)
                                    out_valid |-> $past(in_valid, LAT))
        else begin
            $error("Output strobe without an input at the pipeline latency");
            violations++;
        end

    a_known: assert property (@(posedge clk) disable iff (rst)
                              out_valid |-> !$isunknown({out_r, out_g, out_b}))
        else begin
            $error("Unknown bits on a valid output pixel");
            violations++;
        end

endmodule

bind haze_removal_top haze_removal_props u_props (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .out_valid(out_valid),
    .out_r    (out_r),
    .out_g    (out_g),
    .out_b    (out_b)
);

`default_nettype wire

// File: dv/tb_haze_removal.sv
// Testbench for the dehazing pipeline with stimulus, reference model and scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_haze_removal;

    localparam int PW             = dehaze_pkg::PIX_W;
    localparam int RW             = dehaze_pkg::RGB_W;
    localparam int IW             = dehaze_pkg::INV_A_W;
    localparam int LAT            = dehaze_pkg::PIPE_LAT;
    localparam int EDGE_THRESHOLD = 32;
    localparam int T_MIN          = 26;
    localparam int RST_CYCLES     = 5;
    localparam int IDLE_CYCLES    = 4;
    localparam int BURST_LEN      = 16;
    localparam int RANDOM_LEN     = 200;
    localparam int NUM_TESTS      = 6;
    localparam int TOTAL_STROBES  = 1 + BURST_LEN + 4 + 3 + 8 + RANDOM_LEN;
    // Every test also needs a few cycles to drain the pipeline
    localparam int TIMEOUT_CYCLES = RST_CYCLES + IDLE_CYCLES + TOTAL_STROBES
                                  + NUM_TESTS * (LAT + 4) + LAT + 20;

    logic          clk;
    logic          rst;
    logic          in_valid;
    logic [RW-1:0] win_p1;
    logic [RW-1:0] win_p2;
    logic [RW-1:0] win_p3;
    logic [RW-1:0] win_p4;
    logic [RW-1:0] win_p5;
    logic [RW-1:0] win_p6;
    logic [RW-1:0] win_p7;
    logic [RW-1:0] win_p8;
    logic [RW-1:0] win_p9;
    logic [PW-1:0] atm_r;
    logic [PW-1:0] atm_g;
    logic [PW-1:0] atm_b;
    logic [IW-1:0] inv_atm_r;
    logic [IW-1:0] inv_atm_g;
    logic [IW-1:0] inv_atm_b;
    logic [PW-1:0] out_r;
    logic [PW-1:0] out_g;
    logic [PW-1:0] out_b;
    logic          out_valid;

    integer        seed = 46219;
    int            cycle_count = 0;
    int            errors = 0;
    int            checks = 0;
    int            tests_failed = 0;
    logic [RW-1:0] exp_q [$];
    int            stamp_q [$];

    haze_removal_top UUT (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .win_p1   (win_p1),
        .win_p2   (win_p2),
        .win_p3   (win_p3),
        .win_p4   (win_p4),
        .win_p5   (win_p5),
        .win_p6   (win_p6),
        .win_p7   (win_p7),
        .win_p8   (win_p8),
        .win_p9   (win_p9),
        .atm_r    (atm_r),
        .atm_g    (atm_g),
        .atm_b    (atm_b),
        .inv_atm_r(inv_atm_r),
        .inv_atm_g(inv_atm_g),
        .inv_atm_b(inv_atm_b),
        .out_r    (out_r),
        .out_g    (out_g),
        .out_b    (out_b),
        .out_valid(out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the pipeline never drained", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ========================================
    // Reference model
    // ========================================
    // Pixel k of the window (1 to 9), channel 0 is red
    function automatic int chan(logic [9*RW-1:0] win, int k, int ch);
        return win[(9 - k) * RW + (2 - ch) * PW +: PW];
    endfunction

    function automatic int abs_diff(int a, int b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic logic [RW-1:0] expected_pixel(logic [9*RW-1:0] win, logic [RW-1:0] atm,
                                                     logic [3*IW-1:0] inv);
        int            grad;
        int            acc;
        int            filt [3];
        int            dark_ch;
        int            inv_s;
        int            haze;
        int            trans;
        int            recip;
        int            i_v;
        int            a_v;
        int            s;
        logic [RW-1:0] res;
        grad = abs_diff(chan(win, 4, 1), chan(win, 6, 1))
             + abs_diff(chan(win, 2, 1), chan(win, 8, 1));
        for (int ch = 0; ch < 3; ch++) begin
            acc = 2 * (chan(win, 2, ch) + chan(win, 4, ch) + chan(win, 6, ch) + chan(win, 8, ch));
            if (grad > EDGE_THRESHOLD) begin
                acc += 8 * chan(win, 5, ch);
            end else begin
                acc += 4 * chan(win, 5, ch) + chan(win, 1, ch) + chan(win, 3, ch)
                     + chan(win, 7, ch) + chan(win, 9, ch);
            end
            filt[ch] = acc / 16;
        end
        // Strict compare keeps ties on the earlier channel
        dark_ch = 0;
        for (int ch = 1; ch < 3; ch++) begin
            if (filt[ch] < filt[dark_ch]) begin
                dark_ch = ch;
            end
        end
        inv_s = inv[(2 - dark_ch) * IW +: IW];
        inv_s = inv_s - inv_s / 16;
        haze  = (filt[dark_ch] * inv_s) / 64;
        if (haze > 255) begin
            haze = 255;
        end
        trans = 256 - haze;
        if (trans < T_MIN) begin
            trans = T_MIN;
        end
        recip = 4096 / trans;
        for (int ch = 0; ch < 3; ch++) begin
            i_v = chan(win, 5, ch);
            a_v = atm[(2 - ch) * PW +: PW];
            s   = abs_diff(i_v, a_v) * recip / 16;
            if (s > 255) begin
                s = 255;
            end
            if (i_v >= a_v) begin
                res[(2 - ch) * PW +: PW] = PW'((a_v + s > 255) ? 255 : a_v + s);
            end else begin
                res[(2 - ch) * PW +: PW] = PW'((s > a_v) ? 0 : a_v - s);
            end
        end
        return res;
    endfunction

    // ========================================
    // Scoreboard
    // ========================================
    task automatic check_value(string name, int expected, int actual);
        checks++;
        assert (expected == actual) else begin
            $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Inputs and outputs are both stable at the falling edge
    always @(negedge clk) begin
        if (!rst && in_valid) begin
            exp_q.push_back(expected_pixel({win_p1, win_p2, win_p3, win_p4, win_p5, win_p6,
                                            win_p7, win_p8, win_p9}, {atm_r, atm_g, atm_b},
                                           {inv_atm_r, inv_atm_g, inv_atm_b}));
            stamp_q.push_back(cycle_count);
        end
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("Output at %0t ns arrived with no pixel pending", $time);
                errors++;
            end else begin
                check_value("out_r", exp_q[0][23:16], out_r);
                check_value("out_g", exp_q[0][15:8], out_g);
                check_value("out_b", exp_q[0][7:0], out_b);
                check_value("latency", LAT, cycle_count - stamp_q[0]);
                void'(exp_q.pop_front());
                void'(stamp_q.pop_front());
            end
        end
    end

    // ========================================
    // Stimulus helpers
    // ========================================
    function automatic logic [RW-1:0] rand_pixel();
        return RW'($random(seed));
    endfunction

    function automatic logic [3*IW-1:0] rand_inv();
        return {IW'($random(seed)), IW'($random(seed)), IW'($random(seed))};
    endfunction

    function automatic logic [9*RW-1:0] rand_window();
        logic [9*RW-1:0] w;
        for (int k = 0; k < 9; k++) begin
            w[k*RW +: RW] = rand_pixel();
        end
        return w;
    endfunction

    task automatic send_pixel(logic [9*RW-1:0] win, logic [RW-1:0] atm, logic [3*IW-1:0] inv);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        {win_p1, win_p2, win_p3, win_p4, win_p5, win_p6, win_p7, win_p8, win_p9} = win;
        {atm_r, atm_g, atm_b} = atm;
        {inv_atm_r, inv_atm_g, inv_atm_b} = inv;
    endtask

    task automatic stop_and_report(string name, int err_before, int checks_before);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("Test %-12s %0d checks, %0d errors", name, checks - checks_before,
                 errors - err_before);
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_reset();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("out_valid", 0, out_valid);
        end
        send_pixel(rand_window(), rand_pixel(), rand_inv());
        stop_and_report("reset", e0, c0);
    endtask

    task automatic test_burst();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        repeat (BURST_LEN) send_pixel(rand_window(), rand_pixel(), rand_inv());
        stop_and_report("burst", e0, c0);
    endtask

    task automatic test_pixel_is_light();
        int            e0;
        int            c0;
        logic [RW-1:0] a;
        e0 = errors;
        c0 = checks;
        repeat (4) begin
            a = rand_pixel();
            send_pixel({9{a}}, a, rand_inv());
        end
        stop_and_report("pixel_is_A", e0, c0);
    endtask

    task automatic test_no_haze();
        int              e0;
        int              c0;
        logic [9*RW-1:0] w;
        e0 = errors;
        c0 = checks;
        for (int ch = 0; ch < 3; ch++) begin
            w = rand_window();
            for (int k = 0; k < 9; k++) begin
                w[k * RW + (2 - ch) * PW +: PW] = '0;
            end
            send_pixel(w, rand_pixel(), rand_inv());
        end
        stop_and_report("no_haze", e0, c0);
    endtask

    // Green gradient of 33 selects edge weights, 32 stays smooth
    task automatic test_edge_threshold();
        int              e0;
        int              c0;
        int              base;
        logic [9*RW-1:0] w;
        e0 = errors;
        c0 = checks;
        repeat (4) begin
            base = {$random(seed)} % 200;
            for (int h = 17; h >= 16; h--) begin
                w = rand_window();
                w[7 * RW + PW +: PW] = PW'(base + 16);
                w[5 * RW + PW +: PW] = PW'(base + h);
                w[3 * RW + PW +: PW] = PW'(base);
                w[1 * RW + PW +: PW] = PW'(base);
                send_pixel(w, rand_pixel(), rand_inv());
            end
        end
        stop_and_report("edge_mode", e0, c0);
    endtask

    task automatic test_random();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        repeat (RANDOM_LEN) send_pixel(rand_window(), rand_pixel(), rand_inv());
        stop_and_report("random", e0, c0);
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        {win_p1, win_p2, win_p3, win_p4, win_p5, win_p6, win_p7, win_p8, win_p9} = '0;
        {atm_r, atm_g, atm_b} = '0;
        {inv_atm_r, inv_atm_g, inv_atm_b} = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_burst();
        test_pixel_is_light();
        test_no_haze();
        test_edge_threshold();
        test_random();
        $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 NUM_TESTS, tests_failed, checks, errors, UUT.u_props.violations);
        if (errors == 0 && UUT.u_props.violations == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
design/dehaze_pkg.sv
design/pixel_delay.sv
design/adaptive_window_filter.sv
design/transmission_estimator.sv
design/scene_recovery.sv
design/haze_removal_top.sv
dv/haze_removal_props.sv
dv/tb_haze_removal.sv
